/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_n310_mb_regs
FILELIST = n310_mb_regs.f
OBJ_DIR  = obj_dir
PASS_MSG = >>> PASS

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* hw/mb_clock_ctrl.sv */
// Motherboard clock and PPS control register
// pps source select, pps output enable, ref and meas clock resets,
// plus the ref and meas lock indicators brought into bus_clk
`timescale 1ns/1ps
`default_nettype none

`include "n310_mb_cfg.svh"

module mb_clock_ctrl
  import n310_mb_pkg::*;
(
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  // write port
  input  logic      i_reg_wr_req,
  input  reg_addr_t i_reg_wr_addr,
  input  reg_data_t i_reg_wr_data,
  // read port
  input  logic      i_reg_rd_req,
  input  reg_addr_t i_reg_rd_addr,
  // lock status, async to bus_clk
  input  logic      i_ref_clk_locked,
  input  logic      i_meas_clk_locked,
  // clocking controls
  output pps_sel_t  o_pps_select,
  output logic      o_pps_out_enb,
  output logic      o_ref_clk_reset,
  output logic      o_meas_clk_reset,
  output logic      o_rd_resp,
  output reg_data_t o_rd_data
);

  localparam reg_addr_t ADDR_CLOCK_CTRL = `MB_REG_BASE_MISC + `MB_REG_CLOCK_CTRL;

  logic      ref_locked_ms;
  logic      ref_locked;
  logic      meas_locked_ms;
  logic      meas_locked;
  reg_data_t ctrl_rd_word;

  //////////////////////////////////////////////////
  // control register

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_pps_select     <= `MB_PPS_SEL_RESET;
      o_pps_out_enb    <= 1'b0;
      o_ref_clk_reset  <= 1'b0;
      o_meas_clk_reset <= 1'b0;
    end else if (i_reg_wr_req && (i_reg_wr_addr == ADDR_CLOCK_CTRL)) begin
      o_pps_select     <= i_reg_wr_data[`MB_CLK_PPS_SEL_LSB +: `MB_CLK_PPS_SEL_WIDTH];
      o_pps_out_enb    <= i_reg_wr_data[`MB_CLK_PPS_OUT_ENB];
      o_ref_clk_reset  <= i_reg_wr_data[`MB_CLK_REF_RST];
      o_meas_clk_reset <= i_reg_wr_data[`MB_CLK_MEAS_RST];
    end
  end

  // double-flop the lock bits
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      ref_locked_ms  <= 1'b0;
      ref_locked     <= 1'b0;
      meas_locked_ms <= 1'b0;
      meas_locked    <= 1'b0;
    end else begin
      ref_locked_ms  <= i_ref_clk_locked;
      ref_locked     <= ref_locked_ms;
      meas_locked_ms <= i_meas_clk_locked;
      meas_locked    <= meas_locked_ms;
    end
  end

  //////////////////////////////////////////////////
  // readback

  // unused bits read as zero
  always_comb begin
    ctrl_rd_word = '0;
    ctrl_rd_word[`MB_CLK_PPS_SEL_LSB +: `MB_CLK_PPS_SEL_WIDTH] = o_pps_select;
    ctrl_rd_word[`MB_CLK_PPS_OUT_ENB] = o_pps_out_enb;
    ctrl_rd_word[`MB_CLK_REF_RST]     = o_ref_clk_reset;
    ctrl_rd_word[`MB_CLK_REF_LOCKED]  = ref_locked;
    ctrl_rd_word[`MB_CLK_MEAS_RST]    = o_meas_clk_reset;
    ctrl_rd_word[`MB_CLK_MEAS_LOCKED] = meas_locked;
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= i_reg_rd_req && (i_reg_rd_addr == ADDR_CLOCK_CTRL);
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_reg_rd_req && (i_reg_rd_addr == ADDR_CLOCK_CTRL)) begin
      o_rd_data <= ctrl_rd_word;
    end
  end

endmodule

`default_nettype wire

/* hw/mb_misc_regs.sv */
// Motherboard identity and housekeeping registers
// answers reads of design revision, datestamp, build hash, bus counter,
// number of computation engines and scratch; scratch is writable
`timescale 1ns/1ps
`default_nettype none

`include "n310_mb_cfg.svh"

module mb_misc_regs
  import n310_mb_pkg::*;
(
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  // write port
  input  logic      i_reg_wr_req,
  input  reg_addr_t i_reg_wr_addr,
  input  reg_data_t i_reg_wr_data,
  // read port
  input  logic      i_reg_rd_req,
  input  reg_addr_t i_reg_rd_addr,
  output logic      o_rd_resp,
  output reg_data_t o_rd_data
);

  localparam reg_addr_t ADDR_DESIGN_REV  = `MB_REG_BASE_MISC + `MB_REG_DESIGN_REV;
  localparam reg_addr_t ADDR_DATESTAMP   = `MB_REG_BASE_MISC + `MB_REG_DATESTAMP;
  localparam reg_addr_t ADDR_GIT_HASH    = `MB_REG_BASE_MISC + `MB_REG_GIT_HASH;
  localparam reg_addr_t ADDR_BUS_COUNTER = `MB_REG_BASE_MISC + `MB_REG_BUS_COUNTER;
  localparam reg_addr_t ADDR_NUM_CE      = `MB_REG_BASE_MISC + `MB_REG_NUM_CE;
  localparam reg_addr_t ADDR_SCRATCH     = `MB_REG_BASE_MISC + `MB_REG_SCRATCH;

  localparam compat_t COMPAT_MAJOR = `MB_COMPAT_MAJOR;
  localparam compat_t COMPAT_MINOR = `MB_COMPAT_MINOR;

  reg_data_t scratch_reg;
  reg_data_t bus_counter;

  //////////////////////////////////////////////////
  // free-running counter and scratch

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      bus_counter <= '0;
    end else begin
      bus_counter <= bus_counter + 1'b1; // wraps
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      scratch_reg <= '0;
    end else if (i_reg_wr_req && (i_reg_wr_addr == ADDR_SCRATCH)) begin
      scratch_reg <= i_reg_wr_data;
    end
  end

  //////////////////////////////////////////////////
  // read decode, one cycle to response

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= 1'b0;
      if (i_reg_rd_req) begin
        o_rd_resp <= 1'b1;
        case (i_reg_rd_addr)
          ADDR_DESIGN_REV:  o_rd_data <= {COMPAT_MAJOR, COMPAT_MINOR};
          ADDR_DATESTAMP:   o_rd_data <= `MB_DATESTAMP;
          ADDR_GIT_HASH:    o_rd_data <= `MB_GIT_HASH;
          ADDR_BUS_COUNTER: o_rd_data <= bus_counter; // value at the request edge
          ADDR_NUM_CE:      o_rd_data <= `MB_NUM_CE;
          ADDR_SCRATCH:     o_rd_data <= scratch_reg;
          default:          o_rd_resp <= 1'b0; // not ours, stay quiet
        endcase
      end
    end
  end

  // master waits for each response, so pulses never run together
  a_resp_single_pulse : assert property (
    @(posedge i_bus_clk) disable iff (i_bus_rst)
    o_rd_resp |=> !o_rd_resp
  ) else $error("misc regs read response held for two cycles");

endmodule

`default_nettype wire

/* hw/mb_rd_resp_mux.sv */
// Register port read response merger
// registers the pulse of whichever slave answers and keeps its data
// until the next response; one cycle from slave pulse to output
`timescale 1ns/1ps
`default_nettype none

`include "n310_mb_cfg.svh"

module mb_rd_resp_mux
  import n310_mb_pkg::*;
#(
  parameter int NUM_SLAVES = `MB_NUM_RESP_SLAVES
) (
  input  logic                       i_bus_clk,
  input  logic                       i_bus_rst,
  input  logic      [NUM_SLAVES-1:0] i_sla_rd_resp,
  input  reg_data_t [NUM_SLAVES-1:0] i_sla_rd_data,
  output logic                       o_rd_resp,
  output reg_data_t                  o_rd_data
);

  reg_data_t sel_data;
  logic      any_resp;

  //////////////////////////////////////////////////
  // select

  assign any_resp = |i_sla_rd_resp;

  // and-or select, only one source pulses at a time
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (i_sla_rd_resp[i]) begin
        sel_data = sel_data | i_sla_rd_data[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // output register

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= any_resp;
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (any_resp) begin
      o_rd_data <= sel_data; // held until next response
    end
  end

  // slaves decode disjoint ranges and the master keeps one read in flight
  a_one_responder : assert property (
    @(posedge i_bus_clk) disable iff (i_bus_rst)
    $onehot0(i_sla_rd_resp)
  ) else $error("read response collision, sources %b", i_sla_rd_resp);

endmodule

`default_nettype wire

/* hw/n310_mb_pkg.sv */
// N310 motherboard register types
// register port address and data words, pps select and the
// halves of the design revision word
`default_nettype none

`include "n310_mb_cfg.svh"

package n310_mb_pkg;

  //////////////////////////////////////////////////
  // register port

  // byte address on the register port
  typedef logic [`MB_REG_AWIDTH-1:0] reg_addr_t;

  typedef logic [`MB_REG_DWIDTH-1:0] reg_data_t; // read and write data

  //////////////////////////////////////////////////
  // clock control and identity

  // pps source select, one code per source
  typedef logic [`MB_CLK_PPS_SEL_WIDTH-1:0] pps_sel_t;

  typedef logic [15:0] compat_t; // major or minor compat number

endpackage

`default_nettype wire

/* hw/n310_mb_regs.sv */
// N310 motherboard register block, top level
// register port from the upstream master, fanned out to the misc and
// clock control slaves and passed through to the npio peripheral;
// read responses of all three merged into one registered response
`timescale 1ns/1ps
`default_nettype none

`include "n310_mb_cfg.svh"

module n310_mb_regs
  import n310_mb_pkg::*;
(
  input  logic      i_bus_clk,
  input  logic      i_bus_rst,
  // register port from the master
  input  logic      i_reg_wr_req,
  input  reg_addr_t i_reg_wr_addr,
  input  reg_data_t i_reg_wr_data,
  input  logic      i_reg_rd_req,
  input  reg_addr_t i_reg_rd_addr,
  output logic      o_reg_rd_resp,
  output reg_data_t o_reg_rd_data,
  // register port to npio
  output logic      o_reg_wr_req_npio,
  output reg_addr_t o_reg_wr_addr_npio,
  output reg_data_t o_reg_wr_data_npio,
  output logic      o_reg_rd_req_npio,
  output reg_addr_t o_reg_rd_addr_npio,
  input  logic      i_reg_rd_resp_npio,
  input  reg_data_t i_reg_rd_data_npio,
  // clocking
  input  logic      i_ref_clk_locked,
  input  logic      i_meas_clk_locked,
  output pps_sel_t  o_pps_select,
  output logic      o_pps_out_enb,
  output logic      o_ref_clk_reset,
  output logic      o_meas_clk_reset
);

  logic      misc_rd_resp;
  reg_data_t misc_rd_data;
  logic      clk_rd_resp;
  reg_data_t clk_rd_data;

  //////////////////////////////////////////////////
  // npio passthrough, no decode here
  assign o_reg_wr_req_npio  = i_reg_wr_req;
  assign o_reg_wr_addr_npio = i_reg_wr_addr;
  assign o_reg_wr_data_npio = i_reg_wr_data;
  assign o_reg_rd_req_npio  = i_reg_rd_req;
  assign o_reg_rd_addr_npio = i_reg_rd_addr;

  //////////////////////////////////////////////////
  // internal slaves
  mb_misc_regs u_misc_regs (
    .i_bus_clk     (i_bus_clk),
    .i_bus_rst     (i_bus_rst),
    .i_reg_wr_req  (i_reg_wr_req),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_rd_req  (i_reg_rd_req),
    .i_reg_rd_addr (i_reg_rd_addr),
    .o_rd_resp     (misc_rd_resp),
    .o_rd_data     (misc_rd_data)
  );

  mb_clock_ctrl u_clock_ctrl (
    .i_bus_clk         (i_bus_clk),
    .i_bus_rst         (i_bus_rst),
    .i_reg_wr_req      (i_reg_wr_req),
    .i_reg_wr_addr     (i_reg_wr_addr),
    .i_reg_wr_data     (i_reg_wr_data),
    .i_reg_rd_req      (i_reg_rd_req),
    .i_reg_rd_addr     (i_reg_rd_addr),
    .i_ref_clk_locked  (i_ref_clk_locked),
    .i_meas_clk_locked (i_meas_clk_locked),
    .o_pps_select      (o_pps_select),
    .o_pps_out_enb     (o_pps_out_enb),
    .o_ref_clk_reset   (o_ref_clk_reset),
    .o_meas_clk_reset  (o_meas_clk_reset),
    .o_rd_resp         (clk_rd_resp),
    .o_rd_data         (clk_rd_data)
  );

  // source 0 misc, 1 clock ctrl, 2 npio
  mb_rd_resp_mux #(
    .NUM_SLAVES (`MB_NUM_RESP_SLAVES)
  ) u_rd_resp_mux (
    .i_bus_clk     (i_bus_clk),
    .i_bus_rst     (i_bus_rst),
    .i_sla_rd_resp ({i_reg_rd_resp_npio, clk_rd_resp, misc_rd_resp}),
    .i_sla_rd_data ({i_reg_rd_data_npio, clk_rd_data, misc_rd_data}),
    .o_rd_resp     (o_reg_rd_resp),
    .o_rd_data     (o_reg_rd_data)
  );

endmodule

`default_nettype wire

/* include/n310_mb_cfg.svh */
// N310 motherboard register block configuration
// register port widths, register map, clock control field positions
// and the constants reported by the identity registers
`ifndef N310_MB_CFG_SVH
`define N310_MB_CFG_SVH

//////////////////////////////////////////////////
// register port
`define MB_REG_AWIDTH 14
`define MB_REG_DWIDTH 32

//////////////////////////////////////////////////
// register map, offsets from the misc base
`define MB_REG_BASE_MISC   14'h0000
`define MB_REG_DESIGN_REV  14'h0000 // {compat major, compat minor}
`define MB_REG_DATESTAMP   14'h0004
`define MB_REG_GIT_HASH    14'h0008
`define MB_REG_BUS_COUNTER 14'h000C
`define MB_REG_NUM_CE      14'h0010
`define MB_REG_SCRATCH     14'h0014
`define MB_REG_CLOCK_CTRL  14'h0018

//////////////////////////////////////////////////
// identity values
`define MB_COMPAT_MAJOR 16'd1
`define MB_COMPAT_MINOR 16'd0
`define MB_GIT_HASH     32'hDEADBEEF
`define MB_DATESTAMP    32'h0000_0000
`define MB_NUM_CE       32'd5 // four radios + dram fifo

//////////////////////////////////////////////////
// clock control register fields
`define MB_CLK_PPS_SEL_LSB    0
`define MB_CLK_PPS_SEL_WIDTH  4
`define MB_CLK_PPS_OUT_ENB    4
`define MB_CLK_REF_RST        8
`define MB_CLK_REF_LOCKED     9
`define MB_CLK_MEAS_RST       12
`define MB_CLK_MEAS_LOCKED    13

`define MB_PPS_SEL_RESET 4'h1

// read response sources: misc, clock ctrl, npio
`define MB_NUM_RESP_SLAVES 3

`endif

/* n310_mb_regs.f */
+incdir+include
hw/n310_mb_pkg.sv
hw/mb_misc_regs.sv
hw/mb_clock_ctrl.sv
hw/mb_rd_resp_mux.sv
hw/n310_mb_regs.sv
sim/tb_n310_mb_regs.sv

/* sim/tb_n310_mb_regs.sv */
// Testbench for the N310 motherboard register block
// drives the register port as the upstream master, models the npio
// peripheral and checks every read response against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "n310_mb_cfg.svh"

module tb_n310_mb_regs
  import n310_mb_pkg::*;
();

  localparam int        RST_CYCLES = 10;
  // 37 reads of at most 22 cycles, 28 writes, idle gaps and reset stay under 1000
  localparam int        MAX_CYCLES = 2000;
  localparam int        RESP_WAIT  = 20;
  localparam reg_data_t SEED       = 32'd41342;
  localparam reg_addr_t NPIO_BASE  = 14'h2000;

  localparam reg_addr_t ADDR_DESIGN_REV  = `MB_REG_BASE_MISC + `MB_REG_DESIGN_REV;
  localparam reg_addr_t ADDR_DATESTAMP   = `MB_REG_BASE_MISC + `MB_REG_DATESTAMP;
  localparam reg_addr_t ADDR_GIT_HASH    = `MB_REG_BASE_MISC + `MB_REG_GIT_HASH;
  localparam reg_addr_t ADDR_BUS_COUNTER = `MB_REG_BASE_MISC + `MB_REG_BUS_COUNTER;
  localparam reg_addr_t ADDR_NUM_CE      = `MB_REG_BASE_MISC + `MB_REG_NUM_CE;
  localparam reg_addr_t ADDR_SCRATCH     = `MB_REG_BASE_MISC + `MB_REG_SCRATCH;
  localparam reg_addr_t ADDR_CLOCK_CTRL  = `MB_REG_BASE_MISC + `MB_REG_CLOCK_CTRL;
  localparam reg_addr_t ADDR_UNMAPPED    = 14'h01F0;
  localparam reg_addr_t RESET_ADDRS [6]  = '{ADDR_DESIGN_REV, ADDR_DATESTAMP,
    ADDR_GIT_HASH, ADDR_NUM_CE, ADDR_SCRATCH, ADDR_CLOCK_CTRL};

  logic      i_bus_clk;
  logic      i_bus_rst;
  logic      i_reg_wr_req;
  reg_addr_t i_reg_wr_addr;
  reg_data_t i_reg_wr_data;
  logic      i_reg_rd_req;
  reg_addr_t i_reg_rd_addr;
  logic      o_reg_rd_resp;
  reg_data_t o_reg_rd_data;
  logic      o_reg_wr_req_npio;
  reg_addr_t o_reg_wr_addr_npio;
  reg_data_t o_reg_wr_data_npio;
  logic      o_reg_rd_req_npio;
  reg_addr_t o_reg_rd_addr_npio;
  logic      i_reg_rd_resp_npio;
  reg_data_t i_reg_rd_data_npio;
  logic      i_ref_clk_locked;
  logic      i_meas_clk_locked;
  pps_sel_t  o_pps_select;
  logic      o_pps_out_enb;
  logic      o_ref_clk_reset;
  logic      o_meas_clk_reset;

  // shadow copy of the writable fields
  reg_data_t sh_scratch;
  pps_sel_t  sh_pps_sel;
  logic      sh_pps_enb;
  logic      sh_ref_rst;
  logic      sh_meas_rst;

  reg_addr_t seen_wr_addr; // npio model captures
  reg_data_t seen_wr_data;
  reg_addr_t seen_rd_addr;

  reg_data_t lcg_state;
  int        cycle;
  int        rst_release_cycle;
  int        last_req_cycle;
  int        errors;
  int        checks;
  int        num_tests;
  int        test_err_start;
  string     test_name;
  string     name_q [$]; // outstanding reads, in issue order
  reg_data_t exp_q [$];
  bit        chk_q [$];

  n310_mb_regs DUT (.*);

  //////////////////////////////////////////////////
  // clock and run limit

  always #2 i_bus_clk = ~i_bus_clk;

  always @(posedge i_bus_clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("run stopped at cycle %0d, test %s did not finish", cycle, test_name);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // random data and reference model

  function automatic reg_data_t lcg_step(input reg_data_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic reg_data_t next_rand();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  function automatic reg_data_t npio_data(input reg_addr_t addr);
    return lcg_step(SEED ^ reg_data_t'(addr));
  endfunction

  // clock control layout, also used to compare the control outputs
  function automatic reg_data_t ctrl_word(input pps_sel_t sel, input logic enb,
                                          input logic ref_rst, input logic meas_rst,
                                          input logic ref_lock, input logic meas_lock);
    reg_data_t v;
    v = '0;
    v[`MB_CLK_PPS_SEL_LSB +: `MB_CLK_PPS_SEL_WIDTH] = sel;
    v[`MB_CLK_PPS_OUT_ENB] = enb;
    v[`MB_CLK_REF_RST]     = ref_rst;
    v[`MB_CLK_REF_LOCKED]  = ref_lock;
    v[`MB_CLK_MEAS_RST]    = meas_rst;
    v[`MB_CLK_MEAS_LOCKED] = meas_lock;
    return v;
  endfunction

  function automatic reg_data_t expected_read(input reg_addr_t addr);
    reg_data_t v;
    v = '0;
    if (addr >= NPIO_BASE) begin
      v = npio_data(addr);
    end else begin
      case (addr)
        ADDR_DESIGN_REV: v = {`MB_COMPAT_MAJOR, `MB_COMPAT_MINOR};
        ADDR_DATESTAMP:  v = `MB_DATESTAMP;
        ADDR_GIT_HASH:   v = `MB_GIT_HASH;
        ADDR_NUM_CE:     v = `MB_NUM_CE;
        ADDR_SCRATCH:    v = sh_scratch;
        ADDR_CLOCK_CTRL: v = ctrl_word(sh_pps_sel, sh_pps_enb, sh_ref_rst, sh_meas_rst,
                                       i_ref_clk_locked, i_meas_clk_locked);
        default:         v = '0; // bus counter is checked by its own test
      endcase
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // checks and bus tasks

  task automatic check_value(input string what, input reg_data_t exp, input reg_data_t act);
    checks++;
    assert (act == exp) else begin
      $display("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    num_tests++;
    if (errors == test_err_start) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, errors - test_err_start);
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge i_bus_clk);
    i_reg_wr_req  = 1'b1;
    i_reg_wr_addr = addr;
    i_reg_wr_data = data;
    if (addr == ADDR_SCRATCH) begin
      sh_scratch = data;
    end
    if (addr == ADDR_CLOCK_CTRL) begin
      sh_pps_sel  = data[`MB_CLK_PPS_SEL_LSB +: `MB_CLK_PPS_SEL_WIDTH];
      sh_pps_enb  = data[`MB_CLK_PPS_OUT_ENB];
      sh_ref_rst  = data[`MB_CLK_REF_RST];
      sh_meas_rst = data[`MB_CLK_MEAS_RST];
    end
    @(negedge i_bus_clk);
    i_reg_wr_req = 1'b0;
  endtask

  // one read in flight; waits for the response or gives up after RESP_WAIT
  task automatic issue_read(input string what, input reg_addr_t addr, input bit expect_resp,
                            output reg_data_t data, output bit got);
    int waited;
    @(negedge i_bus_clk);
    i_reg_rd_req   = 1'b1;
    i_reg_rd_addr  = addr;
    last_req_cycle = cycle;
    if (expect_resp) begin
      name_q.push_back(what);
      exp_q.push_back(expected_read(addr));
      chk_q.push_back(addr != ADDR_BUS_COUNTER);
    end
    @(negedge i_bus_clk);
    i_reg_rd_req = 1'b0;
    waited = 0;
    got    = 1'b0;
    data   = '0;
    while (!got && waited < RESP_WAIT) begin
      if (o_reg_rd_resp) begin
        got  = 1'b1;
        data = o_reg_rd_data;
      end else begin
        @(negedge i_bus_clk);
        waited++;
      end
    end
    checks++;
    if (expect_resp) begin
      assert (got) else begin
        $display("no read response to address 0x%04h within %0d cycles", addr, RESP_WAIT);
        errors++;
      end
    end else begin
      assert (!got) else begin
        $display("read of unmapped address 0x%04h got a response", addr);
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // response checker and npio model

  always @(negedge i_bus_clk) begin : resp_checker
    string     what;
    reg_data_t exp;
    bit        chk;
    if (!i_bus_rst && o_reg_rd_resp) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("read response 0x%08h with no read outstanding", o_reg_rd_data);
        errors++;
      end
      if (exp_q.size() != 0) begin
        what = name_q.pop_front();
        exp  = exp_q.pop_front();
        chk  = chk_q.pop_front();
        if (chk) begin
          check_value(what, exp, o_reg_rd_data);
        end
      end
    end
  end

  always @(posedge i_bus_clk) begin
    if (o_reg_wr_req_npio) begin
      seen_wr_addr <= o_reg_wr_addr_npio;
      seen_wr_data <= o_reg_wr_data_npio;
    end
  end

  // answers its own range three cycles after the request
  always begin : npio_reader
    reg_addr_t rd_addr;
    @(posedge i_bus_clk);
    if (!i_bus_rst && o_reg_rd_req_npio && (o_reg_rd_addr_npio >= NPIO_BASE)) begin
      rd_addr      = o_reg_rd_addr_npio;
      seen_rd_addr = rd_addr;
      repeat (2) @(posedge i_bus_clk);
      @(negedge i_bus_clk);
      i_reg_rd_resp_npio = 1'b1;
      i_reg_rd_data_npio = npio_data(rd_addr);
      @(negedge i_bus_clk);
      i_reg_rd_resp_npio = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // test sequence

  initial begin : main
    reg_data_t data;
    reg_data_t c0;
    reg_data_t c1;
    reg_addr_t addr;
    bit        got;
    int        r0;
    int        gap;
    i_bus_clk          = 1'b0;
    i_bus_rst          = 1'b1;
    i_reg_wr_req       = 1'b0;
    i_reg_wr_addr      = '0;
    i_reg_wr_data      = '0;
    i_reg_rd_req       = 1'b0;
    i_reg_rd_addr      = '0;
    i_reg_rd_resp_npio = 1'b0;
    i_reg_rd_data_npio = '0;
    i_ref_clk_locked   = 1'b0;
    i_meas_clk_locked  = 1'b0;
    lcg_state   = SEED;
    sh_scratch  = '0;
    sh_pps_sel  = `MB_PPS_SEL_RESET;
    sh_pps_enb  = 1'b0;
    sh_ref_rst  = 1'b0;
    sh_meas_rst = 1'b0;
    repeat (RST_CYCLES) @(posedge i_bus_clk);
    @(negedge i_bus_clk);
    i_bus_rst         = 1'b0;
    rst_release_cycle = cycle;

    begin_test("reset_values");
    check_value("control outputs", ctrl_word(`MB_PPS_SEL_RESET, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0),
                ctrl_word(o_pps_select, o_pps_out_enb, o_ref_clk_reset, o_meas_clk_reset,
                          1'b0, 1'b0));
    for (int i = 0; i < 6; i++) begin
      issue_read($sformatf("read 0x%04h", RESET_ADDRS[i]), RESET_ADDRS[i], 1'b1, data, got);
    end
    end_test();

    begin_test("scratch");
    repeat (16) begin
      reg_write(ADDR_SCRATCH, next_rand());
      issue_read("scratch readback", ADDR_SCRATCH, 1'b1, data, got);
    end
    end_test();

    begin_test("clock_ctrl");
    repeat (8) begin
      data = next_rand();
      reg_write(ADDR_CLOCK_CTRL, data);
      check_value("control outputs",
                  ctrl_word(sh_pps_sel, sh_pps_enb, sh_ref_rst, sh_meas_rst, 1'b0, 1'b0),
                  ctrl_word(o_pps_select, o_pps_out_enb, o_ref_clk_reset, o_meas_clk_reset,
                            1'b0, 1'b0));
      i_ref_clk_locked  = data[20]; // spare random bits
      i_meas_clk_locked = data[27];
      repeat (4) @(negedge i_bus_clk);
      issue_read("clock_ctrl readback", ADDR_CLOCK_CTRL, 1'b1, data, got);
    end
    end_test();

    begin_test("bus_counter");
    issue_read("first count", ADDR_BUS_COUNTER, 1'b1, c0, got);
    r0 = last_req_cycle;
    check_value("count since reset", reg_data_t'(r0 - rst_release_cycle), c0);
    gap = 5 + int'(next_rand() >> 24) % 32;
    repeat (gap) @(negedge i_bus_clk);
    issue_read("second count", ADDR_BUS_COUNTER, 1'b1, c1, got);
    check_value("count step", reg_data_t'(last_req_cycle - r0), c1 - c0);
    end_test();

    begin_test("npio");
    repeat (4) begin
      addr = NPIO_BASE + reg_addr_t'(next_rand() & 32'h1FFC);
      data = next_rand();
      reg_write(addr, data);
      check_value("npio write addr", reg_data_t'(addr), reg_data_t'(seen_wr_addr));
      check_value("npio write data", data, seen_wr_data);
      issue_read("npio read data", addr, 1'b1, data, got);
      check_value("npio read addr", reg_data_t'(addr), reg_data_t'(seen_rd_addr));
    end
    end_test();

    begin_test("unmapped");
    issue_read("unmapped read", ADDR_UNMAPPED, 1'b0, data, got);
    end_test();

    repeat (4) @(negedge i_bus_clk);
    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
